// ==== project.f ====
logic/fp_add_pkg.sv
logic/fp_add_ctrl.sv
logic/fp_unpack.sv
logic/fp_align.sv
logic/fp_sum_lzc.sv
logic/fp_normalize.sv
logic/fp_round.sv
logic/fp_add_top.sv
bench/fp_add_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build with Verilator, run, then look for the fail message in the log

rm -rf obj_dir sim.log build.log

verilator --binary --timing -Wno-fatal -f project.f --top-module fp_add_tb \
  -o fp_add_sim > build.log 2>&1 \
  || { echo "Verilator build failed, see build.log"; exit 1; }

./obj_dir/fp_add_sim > sim.log 2>&1 || { echo "Simulator exited with an error"; exit 1; }

cat sim.log

grep -q "Simulation failed" sim.log && { echo "Run FAILED"; exit 1; } || { echo "Run PASSED"; exit 0; }

// ==== bench/fp_add_patterns.txt ====
# group operand_a operand_b subtract rounding_mode expected_result expected_flags
# all hex, flags are nv dz of uf nx from bit 4 down
1 3f800000 3f800000 0 0 40000000 00
1 3fc00000 40200000 0 0 40800000 00
1 40400000 3f800000 1 0 40000000 00
1 3f800001 3f800000 1 0 34000000 00
1 3f800000 33800000 1 0 3f7fffff 00
1 3f800000 33800000 0 0 3f800000 01
1 3f800000 33c00000 0 0 3f800001 01
1 bf800000 bf800000 0 0 c0000000 00
1 3fffffff 3fffffff 0 0 407fffff 00
2 3f800000 33800000 0 0 3f800000 01
2 3f800000 33800000 0 1 3f800000 01
2 3f800000 33800000 0 2 3f800000 01
2 3f800000 33800000 0 3 3f800001 01
2 3f800000 33800000 0 4 3f800001 01
2 bf800000 b3800000 0 0 bf800000 01
2 bf800000 b3800000 0 1 bf800000 01
2 bf800000 b3800000 0 2 bf800001 01
2 bf800000 b3800000 0 3 bf800000 01
2 bf800000 b3800000 0 4 bf800001 01
2 3f800000 33800000 0 7 3f800000 01
3 7fc00000 3f800000 0 0 7fc00000 00
3 7f800001 3f800000 0 0 7fc00000 10
3 3f800000 ffc00001 1 0 7fc00000 00
3 3f800000 7fa00000 0 0 7fc00000 10
3 7f800000 7f800000 1 0 7fc00000 10
3 7f800000 ff800000 0 0 7fc00000 10
3 7f800000 3f800000 0 0 7f800000 00
3 ff800000 40a00000 0 0 ff800000 00
3 3f800000 7f800000 1 0 ff800000 00
3 7f800000 7f800000 0 0 7f800000 00
3 3fc00000 3fc00000 1 0 00000000 00
3 3fc00000 3fc00000 1 2 80000000 00
3 80000000 80000000 0 0 80000000 00
3 00000000 80000000 0 0 00000000 00
3 00000000 80000000 0 2 80000000 00
4 7f7fffff 7f7fffff 0 0 7f800000 05
4 7f7fffff 7f7fffff 0 1 7f7fffff 05
4 7f7fffff 7f7fffff 0 2 7f7fffff 05
4 7f7fffff 7f7fffff 0 3 7f800000 05
4 ff7fffff ff7fffff 0 2 ff800000 05
4 ff7fffff ff7fffff 0 3 ff7fffff 05
4 00800001 00800000 1 0 00000000 03
4 00800000 00800001 1 0 80000000 03
4 01000000 00800000 1 0 00800000 00
5 3f800000 3f800000 0 0 40000000 00
5 40400000 3f800000 1 0 40000000 00
5 3f800000 33c00000 0 0 3f800001 01
5 bf800000 bf800000 0 3 c0000000 00

// ==== bench/fp_add_tb.sv ====
`timescale 1ns/1ps

module fp_add_tb;

  localparam int MAX_PATTERNS = 64;
  localparam int CLK_PERIOD   = 40;
  localparam int RESET_CYCLES = 4;
  localparam int LATENCY      = 8;
  // Per pattern at most 8 latency cycles plus 8 for gap and drive
  localparam int TIMEOUT_NS   = MAX_PATTERNS * (8 + 8) * CLK_PERIOD +
                                RESET_CYCLES * CLK_PERIOD + 4000;

  logic                  i_clk;
  logic                  i_rst;
  logic                  i_valid;
  logic [31:0]           i_operand_a;
  logic [31:0]           i_operand_b;
  logic                  i_is_subtract;
  fp_add_pkg::rm_e       i_rounding_mode;
  logic                  o_ready;
  logic                  o_valid;
  logic [31:0]           o_result;
  fp_add_pkg::fp_flags_t o_flags;

  fp_add_top dut_i (
    .i_clk           (i_clk),
    .i_rst           (i_rst),
    .i_valid         (i_valid),
    .i_operand_a     (i_operand_a),
    .i_operand_b     (i_operand_b),
    .i_is_subtract   (i_is_subtract),
    .i_rounding_mode (i_rounding_mode),
    .o_ready         (o_ready),
    .o_valid         (o_valid),
    .o_result        (o_result),
    .o_flags         (o_flags)
  );

  always #(CLK_PERIOD / 2) i_clk = ~i_clk;

  // ====================
  // Pattern storage
  // ====================

  logic [31:0] pat_group [MAX_PATTERNS];
  logic [31:0] pat_a     [MAX_PATTERNS];
  logic [31:0] pat_b     [MAX_PATTERNS];
  logic [31:0] pat_sub   [MAX_PATTERNS];
  logic [31:0] pat_rm    [MAX_PATTERNS];
  logic [31:0] pat_res   [MAX_PATTERNS];
  logic [31:0] pat_flags [MAX_PATTERNS];
  int          pat_count;

  int err_count;
  int ops_passed;
  int ops_failed;
  int group_ops;
  int group_failed;
  bit op_bad;

  function automatic logic [31:0] lcg_next(input logic [31:0] state);
    return state * 32'd1664525 + 32'd1013904223;
  endfunction

  task automatic load_patterns(output bit ok);
    int          fd;
    int          n;
    string       line;
    logic [31:0] f_g, f_a, f_b, f_s, f_r, f_e, f_f;
    ok        = 1'b1;
    pat_count = 0;
    fd = $fopen("bench/fp_add_patterns.txt", "r");
    if (fd == 0) begin
      $display("Could not open the pattern file bench/fp_add_patterns.txt");
      ok = 1'b0;
    end else begin
      while (!$feof(fd)) begin
        line = "";
        n = $fgets(line, fd);
        // Skip blank and comment lines
        if (line.len() > 1 && line[0] != 8'h23) begin
          n = $sscanf(line, "%h %h %h %h %h %h %h", f_g, f_a, f_b, f_s, f_r, f_e, f_f);
          if (n != 7 || pat_count >= MAX_PATTERNS) begin
            $display("Pattern file line could not be used: %s", line);
            ok = 1'b0;
          end else begin
            pat_group[pat_count] = f_g;
            pat_a[pat_count]     = f_a;
            pat_b[pat_count]     = f_b;
            pat_sub[pat_count]   = f_s;
            pat_rm[pat_count]    = f_r;
            pat_res[pat_count]   = f_e;
            pat_flags[pat_count] = f_f;
            pat_count++;
          end
        end
      end
      $fclose(fd);
      if (pat_count == 0) begin
        $display("The pattern file holds no operations");
        ok = 1'b0;
      end
    end
  endtask

  task automatic report_fail(input string msg);
    $display("CHECK FAILED at %0d ns: %s", $time, msg);
    err_count++;
    op_bad = 1'b1;
  endtask

  // Called right after a rising edge
  task automatic drive_op(input int idx);
    i_valid         <= 1'b1;
    i_operand_a     <= pat_a[idx];
    i_operand_b     <= pat_b[idx];
    i_is_subtract   <= pat_sub[idx][0];
    i_rounding_mode <= fp_add_pkg::rm_e'(pat_rm[idx][2:0]);
  endtask

  // ====================
  // One operation
  // ====================

  task automatic run_op(input int idx, input int gap, input bit spurious,
                        input bit preloaded, input bit chain_next);
    int cyc;
    bit done;
    op_bad = 1'b0;
    if (!preloaded) begin
      repeat (gap) begin
        @(posedge i_clk);
        @(negedge i_clk);
        if (o_valid !== 1'b0) report_fail("o_valid high while idle");
        if (o_ready !== 1'b1) report_fail("o_ready low while idle");
      end
      @(posedge i_clk);
      drive_op(idx);
    end
    // Accepting edge
    @(posedge i_clk);
    if (spurious) begin
      // Busy unit must ignore this request and its operands
      i_operand_a <= ~pat_a[idx];
      i_operand_b <= pat_b[idx] ^ 32'h0123_4567;
    end else begin
      i_valid <= 1'b0;
    end
    cyc  = 0;
    done = 1'b0;
    while (!done) begin
      @(negedge i_clk);
      cyc++;
      if (o_valid === 1'b1) begin
        done = 1'b1;
        if (cyc != LATENCY)
          report_fail($sformatf("o_valid after %0d cycles, expected %0d", cyc, LATENCY));
        if (o_ready !== 1'b1) report_fail("o_ready low in the result cycle");
        if (o_result !== pat_res[idx])
          report_fail($sformatf("pattern %0d result %h, expected %h",
                                idx, o_result, pat_res[idx]));
        if (o_flags !== pat_flags[idx][4:0])
          report_fail($sformatf("pattern %0d flags %b, expected %b",
                                idx, o_flags, pat_flags[idx][4:0]));
      end else if (cyc >= 2 * LATENCY) begin
        done = 1'b1;
        $display("Pattern %0d got no o_valid within %0d cycles", idx, cyc);
        err_count++;
        op_bad = 1'b1;
      end else begin
        if (o_ready !== 1'b0) report_fail("o_ready high while busy");
        @(posedge i_clk);
        if (cyc == 3) i_valid <= 1'b0;
        // Back to back, the next request waits at the o_valid edge
        if (cyc == LATENCY - 1 && chain_next) drive_op(idx + 1);
      end
    end
    if (!chain_next) begin
      @(posedge i_clk);
      i_valid <= 1'b0;
      @(negedge i_clk);
      if (o_valid !== 1'b0) report_fail("o_valid longer than one cycle");
    end
    group_ops++;
    if (op_bad) begin
      ops_failed++;
      group_failed++;
    end else begin
      ops_passed++;
    end
  endtask

  // ====================
  // Main sequence
  // ====================

  initial begin
    logic [31:0] seed;
    bit          ok;
    bit          preloaded;
    bit          chain_next;
    i_clk           = 1'b0;
    i_rst           = 1'b1;
    i_valid         = 1'b0;
    i_operand_a     = '0;
    i_operand_b     = '0;
    i_is_subtract   = 1'b0;
    i_rounding_mode = fp_add_pkg::RNE;
    err_count       = 0;
    ops_passed      = 0;
    ops_failed      = 0;
    group_ops       = 0;
    group_failed    = 0;
    seed            = 32'hcf62;
    preloaded       = 1'b0;
    load_patterns(ok);
    repeat (RESET_CYCLES) @(posedge i_clk);
    i_rst <= 1'b0;
    @(negedge i_clk);
    op_bad = 1'b0;
    if (o_valid !== 1'b0) report_fail("o_valid high after reset");
    if (o_ready !== 1'b1) report_fail("o_ready low after reset");
    if (o_result !== 32'h0 || o_flags !== 5'h0) report_fail("outputs not zero after reset");
    if (ok) begin
      for (int i = 0; i < pat_count; i++) begin
        // Group 5 runs back to back with no idle gap
        chain_next = (i + 1 < pat_count) && pat_group[i] == 5 && pat_group[i + 1] == 5;
        seed = lcg_next(seed);
        run_op(i, int'(seed[18:16]), seed[24], preloaded, chain_next);
        preloaded = chain_next;
        if (i + 1 == pat_count || pat_group[i + 1] != pat_group[i]) begin
          $display("Group %0d done: %0d operations, %0d failed",
                   pat_group[i], group_ops, group_failed);
          group_ops    = 0;
          group_failed = 0;
        end
      end
    end
    $display("Totals: %0d operations passed, %0d failed, %0d errors",
             ops_passed, ops_failed, err_count);
    if (!ok || err_count > 0) begin
      $display("Simulation failed");
    end else begin
      $display("Simulation passed");
    end
    $finish;
  end

  // Watchdog
  initial begin
    #(TIMEOUT_NS);
    $display("Timeout: the run did not finish within %0d ns", TIMEOUT_NS);
    $display("Simulation failed");
    $finish;
  end

endmodule

// ==== logic/fp_add_top.sv ====
`timescale 1ns/1ps

module fp_add_top (
  input  logic                          i_clk,
  input  logic                          i_rst,
  input  logic                          i_valid,
  input  logic [fp_add_pkg::WORD_W-1:0] i_operand_a,
  input  logic [fp_add_pkg::WORD_W-1:0] i_operand_b,
  input  logic                          i_is_subtract,
  input  fp_add_pkg::rm_e               i_rounding_mode,
  output logic                          o_ready,
  output logic                          o_valid,
  output logic [fp_add_pkg::WORD_W-1:0] o_result,
  output fp_add_pkg::fp_flags_t         o_flags
);

  // ====================
  // Sequencer
  // ====================

  logic       load;
  logic [6:1] stage_en;

  fp_add_ctrl ctrl_i (
    .i_clk      (i_clk),
    .i_rst      (i_rst),
    .i_valid    (i_valid),
    .o_ready    (o_ready),
    .o_load     (load),
    .o_stage_en (stage_en),
    .o_valid    (o_valid)
  );

  // ====================
  // Datapath
  // ====================

  // Unpack outputs, several held for the whole operation
  logic [fp_add_pkg::MANT_W-1:0] mant_large, mant_small;
  logic [fp_add_pkg::EXP_W-1:0]  exp_large, shift_amt;
  logic                          eff_sub, sign_large, sign_small;
  fp_add_pkg::rm_e               rm;
  logic                          is_special, special_invalid;
  logic [fp_add_pkg::WORD_W-1:0] special_result;

  fp_unpack unpack_i (
    .i_clk             (i_clk),
    .i_rst             (i_rst),
    .i_load            (load),
    .i_en              (stage_en[1]),
    .i_operand_a       (i_operand_a),
    .i_operand_b       (i_operand_b),
    .i_is_subtract     (i_is_subtract),
    .i_rounding_mode   (i_rounding_mode),
    .o_mant_large      (mant_large),
    .o_mant_small      (mant_small),
    .o_exp_large       (exp_large),
    .o_shift_amt       (shift_amt),
    .o_eff_sub         (eff_sub),
    .o_sign_large      (sign_large),
    .o_sign_small      (sign_small),
    .o_rm              (rm),
    .o_is_special      (is_special),
    .o_special_result  (special_result),
    .o_special_invalid (special_invalid)
  );

  logic [fp_add_pkg::EXT_W-1:0] op_large, op_small;
  logic                         align_sticky;

  fp_align align_i (
    .i_clk        (i_clk),
    .i_rst        (i_rst),
    .i_en         (stage_en[2]),
    .i_mant_large (mant_large),
    .i_mant_small (mant_small),
    .i_shift_amt  (shift_amt),
    .o_op_large   (op_large),
    .o_op_small   (op_small),
    .o_sticky     (align_sticky)
  );

  logic        [fp_add_pkg::SUM_W-1:0]  sum;
  logic        [fp_add_pkg::LZC_W-1:0]  lzc;
  logic                                 sum_zero;
  logic signed [fp_add_pkg::SEXP_W-1:0] sum_exp;

  fp_sum_lzc sum_lzc_i (
    .i_clk       (i_clk),
    .i_rst       (i_rst),
    .i_en        (stage_en[3]),
    .i_op_large  (op_large),
    .i_op_small  (op_small),
    .i_eff_sub   (eff_sub),
    .i_exp_large (exp_large),
    .o_sum       (sum),
    .o_lzc       (lzc),
    .o_sum_zero  (sum_zero),
    .o_exp       (sum_exp)
  );

  logic        [fp_add_pkg::SUM_W-1:0]  norm_sum;
  logic signed [fp_add_pkg::SEXP_W-1:0] norm_exp;
  logic                                 ovf_guard;

  fp_normalize normalize_i (
    .i_clk       (i_clk),
    .i_rst       (i_rst),
    .i_en        (stage_en[4]),
    .i_sum       (sum),
    .i_lzc       (lzc),
    .i_sum_zero  (sum_zero),
    .i_exp       (sum_exp),
    .o_norm_sum  (norm_sum),
    .o_norm_exp  (norm_exp),
    .o_ovf_guard (ovf_guard)
  );

  fp_round round_i (
    .i_clk             (i_clk),
    .i_rst             (i_rst),
    .i_en_decide       (stage_en[5]),
    .i_en_output       (stage_en[6]),
    .i_norm_sum        (norm_sum),
    .i_norm_exp        (norm_exp),
    .i_ovf_guard       (ovf_guard),
    .i_align_sticky    (align_sticky),
    .i_sum_zero        (sum_zero),
    .i_sign_large      (sign_large),
    .i_sign_small      (sign_small),
    .i_rm              (rm),
    .i_is_special      (is_special),
    .i_special_result  (special_result),
    .i_special_invalid (special_invalid),
    .o_result          (o_result),
    .o_flags           (o_flags)
  );

endmodule

// ==== logic/fp_round.sv ====
`timescale 1ns/1ps

module fp_round (
  input  logic                                 i_clk,
  input  logic                                 i_rst,
  input  logic                                 i_en_decide,
  input  logic                                 i_en_output,
  input  logic        [fp_add_pkg::SUM_W-1:0]  i_norm_sum,
  input  logic signed [fp_add_pkg::SEXP_W-1:0] i_norm_exp,
  input  logic                                 i_ovf_guard,
  input  logic                                 i_align_sticky,
  input  logic                                 i_sum_zero,
  input  logic                                 i_sign_large,
  input  logic                                 i_sign_small,
  input  fp_add_pkg::rm_e                      i_rm,
  input  logic                                 i_is_special,
  input  logic        [fp_add_pkg::WORD_W-1:0] i_special_result,
  input  logic                                 i_special_invalid,
  output logic        [fp_add_pkg::WORD_W-1:0] o_result,
  output fp_add_pkg::fp_flags_t                o_flags
);

  // ====================
  // Stage 5 decision
  // ====================

  // Mantissa is bits EXT_W-1 down, guard and round just below it
  localparam int LSB = fp_add_pkg::EXT_W - fp_add_pkg::MANT_W;

  logic [fp_add_pkg::MANT_W-1:0] mant;
  logic guard, rnd, sticky, lsb, dropped, round_up;

  assign mant    = i_norm_sum[fp_add_pkg::EXT_W-1:LSB];
  assign guard   = i_norm_sum[LSB-1];
  assign rnd     = i_norm_sum[LSB-2];
  assign sticky  = (|i_norm_sum[LSB-3:0]) | i_ovf_guard | i_align_sticky;
  assign lsb     = mant[0];
  assign dropped = guard | rnd | sticky;

  // Result sign is always the sign of the larger operand
  always_comb begin
    case (i_rm)
      fp_add_pkg::RTZ: round_up = 1'b0;
      fp_add_pkg::RDN: round_up = i_sign_large & dropped;
      fp_add_pkg::RUP: round_up = ~i_sign_large & dropped;
      fp_add_pkg::RMM: round_up = guard;
      default:         round_up = guard & (rnd | sticky | lsb);
    endcase
  end

  logic [fp_add_pkg::MANT_W-1:0]  mant_s6;
  logic signed [fp_add_pkg::SEXP_W-1:0] exp_s6;
  logic round_up_s6, inexact_s6;

  always_ff @(posedge i_clk) begin
    if (i_en_decide) begin
      mant_s6 <= mant;
      exp_s6  <= i_norm_exp;
    end
  end

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      round_up_s6 <= 1'b0;
      inexact_s6  <= 1'b0;
    end else if (i_en_decide) begin
      round_up_s6 <= round_up;
      inexact_s6  <= dropped;
    end
  end

  // ====================
  // Stage 6 apply
  // ====================

  logic [fp_add_pkg::MANT_W:0]          rounded;
  logic signed [fp_add_pkg::SEXP_W-1:0] adj_exp;
  logic [fp_add_pkg::FRAC_W-1:0]        frac;

  assign rounded = {1'b0, mant_s6} + {{fp_add_pkg::MANT_W{1'b0}}, round_up_s6};

  // Rounding all ones up leaves a zero fraction and carries into the exponent
  assign frac = rounded[fp_add_pkg::FRAC_W-1:0];

  always_comb begin
    if (rounded[fp_add_pkg::MANT_W]) begin
      adj_exp = exp_s6 + fp_add_pkg::SEXP_W'(1);
    end else begin
      adj_exp = exp_s6;
    end
  end

  logic overflow, underflow, zero_sign, to_max;

  assign overflow  = adj_exp >=
                     $signed({{(fp_add_pkg::SEXP_W - fp_add_pkg::EXP_W){1'b0}},
                              fp_add_pkg::EXP_MAX});
  // No subnormal outputs, these flush
  assign underflow = adj_exp[fp_add_pkg::SEXP_W-1] | (adj_exp == '0);
  // Exact zero of unlike signs is +0, -0 under RDN
  assign zero_sign = (i_sign_large == i_sign_small) ? i_sign_large : (i_rm == fp_add_pkg::RDN);
  // Modes that round toward zero on overflow
  assign to_max    = (i_rm == fp_add_pkg::RTZ) |
                     ((i_rm == fp_add_pkg::RDN) & ~i_sign_large) |
                     ((i_rm == fp_add_pkg::RUP) & i_sign_large);

  logic [fp_add_pkg::WORD_W-1:0] result;
  fp_add_pkg::fp_flags_t         flags;

  always_comb begin
    flags = '0;
    if (i_is_special) begin
      result   = i_special_result;
      flags.nv = i_special_invalid;
    end else if (i_sum_zero & ~i_align_sticky) begin
      result = {zero_sign, {(fp_add_pkg::WORD_W-1){1'b0}}};
    end else if (overflow) begin
      flags.of = 1'b1;
      flags.nx = 1'b1;
      if (to_max) begin
        result = {i_sign_large, fp_add_pkg::EXP_MAX[fp_add_pkg::EXP_W-1:1], 1'b0,
                  {fp_add_pkg::FRAC_W{1'b1}}};
      end else begin
        result = {i_sign_large, fp_add_pkg::EXP_MAX, {fp_add_pkg::FRAC_W{1'b0}}};
      end
    end else if (underflow) begin
      flags.uf = 1'b1;
      flags.nx = 1'b1;
      result   = {i_sign_large, {(fp_add_pkg::WORD_W-1){1'b0}}};
    end else begin
      flags.nx = inexact_s6;
      result   = {i_sign_large, adj_exp[fp_add_pkg::EXP_W-1:0], frac};
    end
  end

  // Output holds until the next operation finishes
  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      o_result <= '0;
      o_flags  <= '0;
    end else if (i_en_output) begin
      o_result <= result;
      o_flags  <= flags;
    end
  end

endmodule

// ==== logic/fp_normalize.sv ====
`timescale 1ns/1ps

module fp_normalize (
  input  logic                                 i_clk,
  input  logic                                 i_rst,
  input  logic                                 i_en,
  input  logic        [fp_add_pkg::SUM_W-1:0]  i_sum,
  input  logic        [fp_add_pkg::LZC_W-1:0]  i_lzc,
  input  logic                                 i_sum_zero,
  input  logic signed [fp_add_pkg::SEXP_W-1:0] i_exp,
  output logic        [fp_add_pkg::SUM_W-1:0]  o_norm_sum,
  output logic signed [fp_add_pkg::SEXP_W-1:0] o_norm_exp,
  output logic                                 o_ovf_guard
);

  // Target is the leading one at bit EXT_W-1, one below the carry
  logic carry;
  logic [fp_add_pkg::LZC_W-1:0] norm_shift;

  assign carry      = i_sum[fp_add_pkg::SUM_W-1];
  assign norm_shift = (i_lzc > fp_add_pkg::LZC_W'(1)) ? i_lzc - fp_add_pkg::LZC_W'(1) : '0;

  logic        [fp_add_pkg::SUM_W-1:0]  norm_sum;
  logic signed [fp_add_pkg::SEXP_W-1:0] norm_exp;

  always_comb begin
    if (i_sum_zero) begin
      norm_sum = '0;
      norm_exp = '0;
    end else if (carry) begin
      // Carry out of a like-signed add
      norm_sum = i_sum >> 1;
      norm_exp = i_exp + fp_add_pkg::SEXP_W'(1);
    end else begin
      // Cancellation, zero shift when already in place
      norm_sum = i_sum << norm_shift;
      norm_exp = i_exp -
                 $signed({{(fp_add_pkg::SEXP_W - fp_add_pkg::LZC_W){1'b0}}, norm_shift});
    end
  end

  always_ff @(posedge i_clk) begin
    if (i_en) begin
      o_norm_sum <= norm_sum;
      o_norm_exp <= norm_exp;
    end
  end

  // Bit lost by the right shift, feeds sticky later
  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      o_ovf_guard <= 1'b0;
    end else if (i_en) begin
      o_ovf_guard <= carry & i_sum[0];
    end
  end

endmodule

// ==== logic/fp_sum_lzc.sv ====
`timescale 1ns/1ps

module fp_sum_lzc (
  input  logic                                i_clk,
  input  logic                                i_rst,
  input  logic                                i_en,
  input  logic        [fp_add_pkg::EXT_W-1:0] i_op_large,
  input  logic        [fp_add_pkg::EXT_W-1:0] i_op_small,
  input  logic                                i_eff_sub,
  input  logic        [fp_add_pkg::EXP_W-1:0] i_exp_large,
  output logic        [fp_add_pkg::SUM_W-1:0] o_sum,
  output logic        [fp_add_pkg::LZC_W-1:0] o_lzc,
  output logic                                o_sum_zero,
  output logic signed [fp_add_pkg::SEXP_W-1:0] o_exp
);

  // Large is never below small in magnitude, no borrow out
  logic [fp_add_pkg::SUM_W-1:0] sum;

  assign sum = i_eff_sub ? {1'b0, i_op_large} - {1'b0, i_op_small}
                         : {1'b0, i_op_large} + {1'b0, i_op_small};

  // Priority scan, the highest set bit is the last to write
  logic [fp_add_pkg::LZC_W-1:0] lzc;

  always_comb begin
    lzc = '0;
    for (int i = 0; i < fp_add_pkg::SUM_W; i++) begin
      if (sum[i]) begin
        lzc = fp_add_pkg::LZC_W'(fp_add_pkg::SUM_W - 1 - i);
      end
    end
  end

  always_ff @(posedge i_clk) begin
    if (i_en) begin
      o_sum <= sum;
      o_lzc <= lzc;
      // Widen so normalization can step below zero
      o_exp <= $signed({{(fp_add_pkg::SEXP_W - fp_add_pkg::EXP_W){1'b0}}, i_exp_large});
    end
  end

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      o_sum_zero <= 1'b0;
    end else if (i_en) begin
      o_sum_zero <= (sum == '0);
    end
  end

endmodule

// ==== logic/fp_align.sv ====
`timescale 1ns/1ps

module fp_align (
  input  logic                          i_clk,
  input  logic                          i_rst,
  input  logic                          i_en,
  input  logic [fp_add_pkg::MANT_W-1:0] i_mant_large,
  input  logic [fp_add_pkg::MANT_W-1:0] i_mant_small,
  input  logic [fp_add_pkg::EXP_W-1:0]  i_shift_amt,
  output logic [fp_add_pkg::EXT_W-1:0]  o_op_large,
  output logic [fp_add_pkg::EXT_W-1:0]  o_op_small,
  output logic                          o_sticky
);

  // Mantissas sit in the top half, room below for shifted-out bits
  logic [fp_add_pkg::EXT_W-1:0] ext_large, ext_small;

  assign ext_large = {i_mant_large, {(fp_add_pkg::EXT_W - fp_add_pkg::MANT_W){1'b0}}};
  assign ext_small = {i_mant_small, {(fp_add_pkg::EXT_W - fp_add_pkg::MANT_W){1'b0}}};

  // Past EXT_W everything is gone anyway
  logic [fp_add_pkg::EXP_W-1:0] shift_sat;

  assign shift_sat = (i_shift_amt > fp_add_pkg::EXP_W'(fp_add_pkg::EXT_W)) ?
                     fp_add_pkg::EXP_W'(fp_add_pkg::EXT_W) : i_shift_amt;

  // Barrel shift plus a mask of the bits that fall off the end
  logic [fp_add_pkg::EXT_W-1:0] shifted, lost_mask;

  assign shifted   = ext_small >> shift_sat;
  assign lost_mask = ~({fp_add_pkg::EXT_W{1'b1}} << shift_sat);

  always_ff @(posedge i_clk) begin
    if (i_en) begin
      o_op_large <= ext_large;
      o_op_small <= shifted;
    end
  end

  // Held until the next operation, read again in rounding
  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      o_sticky <= 1'b0;
    end else if (i_en) begin
      o_sticky <= |(ext_small & lost_mask);
    end
  end

endmodule

// ==== logic/fp_unpack.sv ====
`timescale 1ns/1ps

module fp_unpack (
  input  logic                            i_clk,
  input  logic                            i_rst,
  input  logic                            i_load,
  input  logic                            i_en,
  input  logic [fp_add_pkg::WORD_W-1:0]   i_operand_a,
  input  logic [fp_add_pkg::WORD_W-1:0]   i_operand_b,
  input  logic                            i_is_subtract,
  input  fp_add_pkg::rm_e                 i_rounding_mode,
  output logic [fp_add_pkg::MANT_W-1:0]   o_mant_large,
  output logic [fp_add_pkg::MANT_W-1:0]   o_mant_small,
  output logic [fp_add_pkg::EXP_W-1:0]    o_exp_large,
  output logic [fp_add_pkg::EXP_W-1:0]    o_shift_amt,
  output logic                            o_eff_sub,
  output logic                            o_sign_large,
  output logic                            o_sign_small,
  output fp_add_pkg::rm_e                 o_rm,
  output logic                            o_is_special,
  output logic [fp_add_pkg::WORD_W-1:0]   o_special_result,
  output logic                            o_special_invalid
);

  // ====================
  // Operand capture
  // ====================

  // b is stored with its effective sign, FSUB flips it here
  logic [fp_add_pkg::WORD_W-1:0] op_a;
  logic [fp_add_pkg::WORD_W-1:0] op_b;

  always_ff @(posedge i_clk) begin
    if (i_load) begin
      op_a <= i_operand_a;
      op_b <= {i_operand_b[fp_add_pkg::WORD_W-1] ^ i_is_subtract,
               i_operand_b[fp_add_pkg::WORD_W-2:0]};
    end
  end

  // Rounding mode stays put until the next load
  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      o_rm <= fp_add_pkg::RNE;
    end else if (i_load) begin
      o_rm <= i_rounding_mode;
    end
  end

  // ====================
  // Field decode
  // ====================

  logic                          sign_a, sign_b;
  logic [fp_add_pkg::EXP_W-1:0]  exp_a, exp_b;
  logic [fp_add_pkg::FRAC_W-1:0] frac_a, frac_b;

  assign {sign_a, exp_a, frac_a} = op_a;
  assign {sign_b, exp_b, frac_b} = op_b;

  logic zero_exp_a, zero_exp_b, zero_frac_a, zero_frac_b;
  logic max_exp_a, max_exp_b;

  assign zero_exp_a  = (exp_a == '0);
  assign zero_exp_b  = (exp_b == '0);
  assign zero_frac_a = (frac_a == '0);
  assign zero_frac_b = (frac_b == '0);
  assign max_exp_a   = (exp_a == fp_add_pkg::EXP_MAX);
  assign max_exp_b   = (exp_b == fp_add_pkg::EXP_MAX);

  logic inf_a, inf_b, nan_a, nan_b, snan_a, snan_b;

  assign inf_a  = max_exp_a & zero_frac_a;
  assign inf_b  = max_exp_b & zero_frac_b;
  assign nan_a  = max_exp_a & ~zero_frac_a;
  assign nan_b  = max_exp_b & ~zero_frac_b;
  // Quiet bit clear means signalling
  assign snan_a = nan_a & ~frac_a[fp_add_pkg::FRAC_W-1];
  assign snan_b = nan_b & ~frac_b[fp_add_pkg::FRAC_W-1];

  // Subnormals run with exponent one and no hidden bit
  logic [fp_add_pkg::EXP_W-1:0]  exp_adj_a, exp_adj_b;
  logic [fp_add_pkg::MANT_W-1:0] mant_a, mant_b;

  assign exp_adj_a = (zero_exp_a & ~zero_frac_a) ? fp_add_pkg::EXP_W'(1) : exp_a;
  assign exp_adj_b = (zero_exp_b & ~zero_frac_b) ? fp_add_pkg::EXP_W'(1) : exp_b;
  assign mant_a    = {~zero_exp_a, frac_a};
  assign mant_b    = {~zero_exp_b, frac_b};

  // ====================
  // Special results
  // ====================

  logic                          is_special;
  logic [fp_add_pkg::WORD_W-1:0] special_result;
  logic                          special_invalid;

  always_comb begin
    is_special      = 1'b1;
    special_result  = fp_add_pkg::CANON_NAN;
    special_invalid = 1'b0;
    if (nan_a | nan_b) begin
      // Any NaN in gives the canonical NaN, only sNaN is invalid
      special_invalid = snan_a | snan_b;
    end else if (inf_a & inf_b & (sign_a != sign_b)) begin
      // inf - inf
      special_invalid = 1'b1;
    end else if (inf_a) begin
      special_result = {sign_a, fp_add_pkg::EXP_MAX, {fp_add_pkg::FRAC_W{1'b0}}};
    end else if (inf_b) begin
      special_result = {sign_b, fp_add_pkg::EXP_MAX, {fp_add_pkg::FRAC_W{1'b0}}};
    end else begin
      is_special = 1'b0;
    end
  end

  // ====================
  // Magnitude order
  // ====================

  // Exponent first, mantissa breaks a tie
  logic swap;

  assign swap = (exp_adj_b > exp_adj_a) | ((exp_adj_b == exp_adj_a) & (mant_b > mant_a));

  always_ff @(posedge i_clk) begin
    if (i_en) begin
      o_mant_large <= swap ? mant_b : mant_a;
      o_mant_small <= swap ? mant_a : mant_b;
      o_exp_large  <= swap ? exp_adj_b : exp_adj_a;
      o_shift_amt  <= swap ? exp_adj_b - exp_adj_a : exp_adj_a - exp_adj_b;
      o_sign_large <= swap ? sign_b : sign_a;
      o_sign_small <= swap ? sign_a : sign_b;
      o_eff_sub    <= sign_a ^ sign_b;
      o_special_result <= special_result;
    end
  end

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      o_is_special      <= 1'b0;
      o_special_invalid <= 1'b0;
    end else if (i_en) begin
      o_is_special      <= is_special;
      o_special_invalid <= special_invalid;
    end
  end

endmodule

// ==== logic/fp_add_ctrl.sv ====
`timescale 1ns/1ps

module fp_add_ctrl (
  input  logic       i_clk,
  input  logic       i_rst,
  input  logic       i_valid,
  output logic       o_ready,
  output logic       o_load,
  output logic [6:1] o_stage_en,
  output logic       o_valid
);

  // One state per stage register, no pipelining
  typedef enum logic [2:0] {
    IDLE   = 3'd0,
    STAGE1 = 3'd1,
    STAGE2 = 3'd2,
    STAGE3 = 3'd3,
    STAGE4 = 3'd4,
    STAGE5 = 3'd5,
    STAGE6 = 3'd6,
    STAGE7 = 3'd7
  } state_e;

  state_e state;
  state_e next_state;

  // Only accept while idle, i_valid is ignored otherwise
  assign o_ready = (state == IDLE);
  assign o_load  = o_ready & i_valid;

  always_comb begin
    case (state)
      IDLE:    next_state = o_load ? STAGE1 : IDLE;
      STAGE1:  next_state = STAGE2;
      STAGE2:  next_state = STAGE3;
      STAGE3:  next_state = STAGE4;
      STAGE4:  next_state = STAGE5;
      STAGE5:  next_state = STAGE6;
      STAGE6:  next_state = STAGE7;
      default: next_state = IDLE;
    endcase
  end

  // One-hot enable, bit k loads the stage-k register
  always_comb begin
    o_stage_en = '0;
    case (state)
      STAGE1:  o_stage_en[1] = 1'b1;
      STAGE2:  o_stage_en[2] = 1'b1;
      STAGE3:  o_stage_en[3] = 1'b1;
      STAGE4:  o_stage_en[4] = 1'b1;
      STAGE5:  o_stage_en[5] = 1'b1;
      STAGE6:  o_stage_en[6] = 1'b1;
      default: o_stage_en = '0;
    endcase
  end

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      state   <= IDLE;
      o_valid <= 1'b0;
    end else begin
      state   <= next_state;
      // Result register was loaded in STAGE6, pulse one cycle later
      o_valid <= (state == STAGE7);
    end
  end

endmodule

// ==== logic/fp_add_pkg.sv ====
package fp_add_pkg;

  // ====================
  // Single-precision format
  // ====================

  localparam int WORD_W = 32;
  localparam int EXP_W  = 8;
  localparam int FRAC_W = 23;
  // Fraction plus hidden bit
  localparam int MANT_W = FRAC_W + 1;
  // Aligned mantissa keeps a full mantissa of bits below the lsb
  localparam int EXT_W  = 2 * MANT_W;
  // One carry bit above the aligned operands
  localparam int SUM_W  = EXT_W + 1;
  localparam int LZC_W  = 6;
  // Working exponent, signed so that cancellation can go below zero
  localparam int SEXP_W = EXP_W + 2;

  localparam logic [EXP_W-1:0]  EXP_MAX   = '1;
  localparam logic [WORD_W-1:0] CANON_NAN = 32'h7fc0_0000;

  // Rounding modes, unknown codes are handled as RNE
  typedef enum logic [2:0] {
    RNE = 3'd0,
    RTZ = 3'd1,
    RDN = 3'd2,
    RUP = 3'd3,
    RMM = 3'd4
  } rm_e;

  // Exception flags, dz is never raised by an adder
  typedef struct packed {
    logic nv;
    logic dz;
    logic of;
    logic uf;
    logic nx;
  } fp_flags_t;

endpackage
